// File: hw/issue_settings.svh
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// fetch queue entries, power of two
`define ISSUE_QUEUE_DEPTH 8

// reorder buffer entries, power of two
`define ISSUE_ROB_DEPTH 16
`define ISSUE_TAG_W $clog2(`ISSUE_ROB_DEPTH)

// architectural registers
`define ISSUE_REG_COUNT 32
`define ISSUE_REG_W $clog2(`ISSUE_REG_COUNT)

`endif

// File: hw/issue_pkg.sv
`default_nettype none

`include "issue_settings.svh"

package issue_pkg;

	typedef logic [`ISSUE_REG_W-1:0] reg_addr_t;
	typedef logic [`ISSUE_TAG_W-1:0] rob_tag_t;

	// register format view
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_r_t;

	// immediate and jump format view
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_word_u;

	typedef enum logic [2:0] {
		FU_ALU,
		FU_LOAD,
		FU_STORE,
		FU_BRANCH,
		FU_MUL,
		FU_CP0,
		FU_NONE
	} fu_t;

	typedef struct packed {
		fu_t       fu;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic      is_controlflow;
	} decoded_instr_t;

	// opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_COP0    = 6'h10;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// special functions
	localparam logic [5:0] FN_JR    = 6'h08;
	localparam logic [5:0] FN_JALR  = 6'h09;
	localparam logic [5:0] FN_MULT  = 6'h18;
	localparam logic [5:0] FN_MULTU = 6'h19;
	localparam logic [5:0] FN_DIV   = 6'h1a;
	localparam logic [5:0] FN_DIVU  = 6'h1b;

	// cop0 sub-ops in the rs field
	localparam logic [4:0] CP0_MT = 5'h04;

endpackage

`default_nettype wire

// File: hw/fetch_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module fetch_queue import issue_pkg::*; (
	input  wire logic              clk,
	input  wire logic              reset_i,
	input  wire logic        [1:0] push_valid_i,
	input  wire instr_word_u [1:0] push_instr_i,
	output logic                   push_ready_o,
	input  wire logic        [1:0] pop_count_i,
	output logic             [1:0] head_valid_o,
	output instr_word_u      [1:0] head_instr_o
);

	localparam int QW = $clog2(`ISSUE_QUEUE_DEPTH);
	localparam logic [QW:0] READY_MAX = (QW+1)'(`ISSUE_QUEUE_DEPTH - 2);

	instr_word_u mem [`ISSUE_QUEUE_DEPTH];

	logic [QW-1:0] wptr;
	logic [QW-1:0] rptr;
	logic [QW:0]   count;
	logic [QW-1:0] wptr_inc;
	logic [QW-1:0] rptr_inc;
	logic [1:0]    push_num;

	assign wptr_inc = wptr + QW'(1);
	assign rptr_inc = rptr + QW'(1);

	// room for a full pair
	assign push_ready_o = (count <= READY_MAX);

	always_comb begin
		push_num = 2'd0;
		if (push_ready_o && push_valid_i[0]) begin
			push_num = push_valid_i[1] ? 2'd2 : 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			wptr  <= wptr + QW'(push_num);
			rptr  <= rptr + QW'(pop_count_i);
			count <= count + (QW+1)'(push_num) - (QW+1)'(pop_count_i);
		end
	end

	always_ff @(posedge clk) begin
		if (push_num != 2'd0) begin
			mem[wptr] <= push_instr_i[0];
		end
		if (push_num == 2'd2) begin
			mem[wptr_inc] <= push_instr_i[1];
		end
	end

	// two oldest words
	assign head_valid_o[0] = (count != '0);
	assign head_valid_o[1] = (count > (QW+1)'(1));
	assign head_instr_o[0] = mem[rptr];
	assign head_instr_o[1] = mem[rptr_inc];

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder import issue_pkg::*; (
	input  wire instr_word_u instr_i,
	output decoded_instr_t   decoded_o
);

	always_comb begin
		// immediate format by default
		decoded_o.fu             = FU_ALU;
		decoded_o.rs1            = instr_i.i.rs;
		decoded_o.rs2            = '0;
		decoded_o.rd             = instr_i.i.rt;
		decoded_o.is_controlflow = 1'b0;

		case (instr_i.i.opcode)
			OP_SPECIAL: begin
				decoded_o.rs2 = instr_i.r.rt;
				decoded_o.rd  = instr_i.r.rd;
				case (instr_i.r.funct)
					FN_JR, FN_JALR: begin
						decoded_o.fu             = FU_BRANCH;
						decoded_o.rs2            = '0;
						decoded_o.is_controlflow = 1'b1;
					end
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
						// hi/lo are not renamed
						decoded_o.fu = FU_MUL;
						decoded_o.rd = '0;
					end
					default: begin
						decoded_o.fu = FU_ALU;
					end
				endcase
			end
			OP_REGIMM: begin
				decoded_o.fu             = FU_BRANCH;
				decoded_o.is_controlflow = 1'b1;
				// bltzal and bgezal link into r31
				decoded_o.rd = instr_i.i.rt[4] ? reg_addr_t'(31) : '0;
			end
			OP_BEQ, OP_BNE: begin
				decoded_o.fu             = FU_BRANCH;
				decoded_o.rs2            = instr_i.i.rt;
				decoded_o.rd             = '0;
				decoded_o.is_controlflow = 1'b1;
			end
			OP_BLEZ, OP_BGTZ: begin
				decoded_o.fu             = FU_BRANCH;
				decoded_o.rd             = '0;
				decoded_o.is_controlflow = 1'b1;
			end
			OP_J, OP_JAL: begin
				decoded_o.fu             = FU_BRANCH;
				decoded_o.rs1            = '0;
				decoded_o.rd             = (instr_i.i.opcode == OP_JAL) ? reg_addr_t'(31) : '0;
				decoded_o.is_controlflow = 1'b1;
			end
			OP_LW: begin
				decoded_o.fu = FU_LOAD;
			end
			OP_SW: begin
				decoded_o.fu  = FU_STORE;
				decoded_o.rs2 = instr_i.i.rt;
				decoded_o.rd  = '0;
			end
			OP_COP0: begin
				decoded_o.fu  = FU_CP0;
				decoded_o.rs1 = '0;
				// mtc0 reads rt, mfc0 writes it
				if (instr_i.i.rs == CP0_MT) begin
					decoded_o.rs2 = instr_i.i.rt;
					decoded_o.rd  = '0;
				end
			end
			default: begin
				decoded_o.fu = FU_ALU;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/pair_issue.sv
`timescale 1ns/10ps
`default_nettype none

module pair_issue import issue_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 reset_i,
	input  wire logic           [1:0] head_valid_i,
	input  wire decoded_instr_t [1:0] decoded_i,
	input  wire logic                 lsu_locked_i,
	input  wire logic                 rob_full_i,
	input  wire rob_tag_t       [1:0] rob_tag_i,
	input  wire logic           [3:0] src_busy_i,
	input  wire rob_tag_t       [3:0] src_tag_i,
	output logic                [1:0] pop_count_o,
	output reg_addr_t           [3:0] src_addr_o,
	output logic                [1:0] status_we_o,
	output reg_addr_t           [1:0] status_rd_o,
	output rob_tag_t            [1:0] status_tag_o,
	output logic                [1:0] issue_valid_o,
	output fu_t                 [1:0] issue_fu_o,
	output rob_tag_t            [1:0] issue_tag_o,
	output logic                [1:0] issue_delayslot_o,
	output logic           [1:0][1:0] issue_src_ready_o,
	output rob_tag_t       [1:0][1:0] issue_src_tag_o
);

	fu_t  fu0;
	fu_t  fu1;
	logic cf0;
	logic slot0_ok;
	logic pair_ok;
	logic slot1_ok;
	logic stall;
	logic issue0;
	logic issue1;

	logic     [1:0][1:0] src_ready;
	rob_tag_t [1:0][1:0] src_tag;

	assign fu0 = decoded_i[0].fu;
	assign fu1 = decoded_i[1].fu;
	assign cf0 = decoded_i[0].is_controlflow;

	assign slot0_ok = head_valid_i[0] && !(fu0 == FU_LOAD && lsu_locked_i);

	// structural limits on a second instruction
	assign pair_ok = !decoded_i[1].is_controlflow
		&& fu0 != FU_MUL && fu1 != FU_MUL
		&& fu0 != FU_CP0 && fu1 != FU_CP0
		&& !(fu0 == FU_STORE && (fu1 == FU_STORE || fu1 == FU_LOAD));

	// a delay slot goes with its branch regardless of pairing limits
	assign slot1_ok = head_valid_i[1]
		&& !(fu1 == FU_LOAD && lsu_locked_i)
		&& (cf0 || pair_ok);

	assign stall  = rob_full_i || (cf0 && !slot1_ok);
	assign issue0 = slot0_ok && !stall;
	assign issue1 = issue0 && slot1_ok;

	assign pop_count_o = {1'b0, issue0} + {1'b0, issue1};

	assign src_addr_o[0] = decoded_i[0].rs1;
	assign src_addr_o[1] = decoded_i[0].rs2;
	assign src_addr_o[2] = decoded_i[1].rs1;
	assign src_addr_o[3] = decoded_i[1].rs2;

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			for (int k = 0; k < 2; k++) begin
				src_ready[s][k] = ~src_busy_i[2*s+k];
				src_tag[s][k]   = src_tag_i[2*s+k];
			end
		end
		// slot 1 reads what slot 0 produces
		if (decoded_i[0].rd != '0 && decoded_i[0].rd == decoded_i[1].rs1) begin
			src_ready[1][0] = 1'b0;
			src_tag[1][0]   = rob_tag_i[0];
		end
		if (decoded_i[0].rd != '0 && decoded_i[0].rd == decoded_i[1].rs2) begin
			src_ready[1][1] = 1'b0;
			src_tag[1][1]   = rob_tag_i[0];
		end
	end

	assign status_we_o[0]  = issue0 && decoded_i[0].rd != '0;
	assign status_we_o[1]  = issue1 && decoded_i[1].rd != '0;
	assign status_rd_o[0]  = decoded_i[0].rd;
	assign status_rd_o[1]  = decoded_i[1].rd;
	assign status_tag_o    = rob_tag_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			issue_valid_o <= '0;
		end else begin
			issue_valid_o <= {issue1, issue0};
		end
	end

	always_ff @(posedge clk) begin
		issue_fu_o[0]        <= fu0;
		issue_fu_o[1]        <= fu1;
		issue_tag_o          <= rob_tag_i;
		issue_delayslot_o    <= {cf0, 1'b0};
		issue_src_ready_o    <= src_ready;
		issue_src_tag_o      <= src_tag;
	end

endmodule

`default_nettype wire

// File: hw/reg_status_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module reg_status_table import issue_pkg::*; (
	input  wire logic            clk,
	input  wire logic            reset_i,
	input  wire reg_addr_t [3:0] raddr_i,
	output logic           [3:0] rbusy_o,
	output rob_tag_t       [3:0] rtag_o,
	input  wire logic      [1:0] we_i,
	input  wire reg_addr_t [1:0] waddr_i,
	input  wire rob_tag_t  [1:0] wtag_i,
	input  wire logic            clear_i,
	input  wire reg_addr_t       clear_rd_i,
	input  wire rob_tag_t        clear_tag_i
);

	logic [`ISSUE_REG_COUNT-1:0] busy;
	rob_tag_t                    tag [`ISSUE_REG_COUNT];

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			rbusy_o[i] = busy[raddr_i[i]];
			rtag_o[i]  = tag[raddr_i[i]];
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			busy <= '0;
			for (int r = 0; r < `ISSUE_REG_COUNT; r++) begin
				tag[r] <= '0;
			end
		end else begin
			// only the newest producer retires the entry
			if (clear_i && tag[clear_rd_i] == clear_tag_i) begin
				busy[clear_rd_i] <= 1'b0;
			end
			// later writes win, so slot 1 beats slot 0 and issue beats clear
			for (int w = 0; w < 2; w++) begin
				if (we_i[w] && waddr_i[w] != '0) begin
					busy[waddr_i[w]] <= 1'b1;
					tag[waddr_i[w]]  <= wtag_i[w];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/rob_alloc.sv
`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module rob_alloc import issue_pkg::*; (
	input  wire logic            clk,
	input  wire logic            reset_i,
	input  wire logic      [1:0] issue_count_i,
	input  wire reg_addr_t [1:0] issue_rd_i,
	input  wire logic            commit_i,
	output rob_tag_t       [1:0] next_tag_o,
	output logic                 rob_full_o,
	output logic                 clear_o,
	output reg_addr_t            clear_rd_o,
	output rob_tag_t             clear_tag_o
);

	localparam int TW = `ISSUE_TAG_W;
	localparam logic [TW:0] FULL_MIN = (TW+1)'(`ISSUE_ROB_DEPTH - 1);

	reg_addr_t   rd_mem [`ISSUE_ROB_DEPTH];
	rob_tag_t    head;
	rob_tag_t    tail;
	logic [TW:0] count;
	logic        commit_ok;

	assign commit_ok = commit_i && (count != '0);

	assign next_tag_o[0] = tail;
	assign next_tag_o[1] = tail + TW'(1);

	// fewer than two free
	assign rob_full_o = (count >= FULL_MIN);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			head  <= head + TW'(commit_ok);
			tail  <= tail + TW'(issue_count_i);
			count <= count + (TW+1)'(issue_count_i) - (TW+1)'(commit_ok);
		end
	end

	always_ff @(posedge clk) begin
		if (issue_count_i != 2'd0) begin
			rd_mem[tail] <= issue_rd_i[0];
		end
		if (issue_count_i == 2'd2) begin
			rd_mem[next_tag_o[1]] <= issue_rd_i[1];
		end
	end

	// retire oldest
	assign clear_o     = commit_ok;
	assign clear_rd_o  = rd_mem[head];
	assign clear_tag_o = head;

endmodule

`default_nettype wire

// File: hw/issue_stage.sv
`timescale 1ns/10ps
`default_nettype none

module issue_stage (
	input  wire logic                         clk,
	input  wire logic                         reset_i,
	input  wire logic                   [1:0] fetch_valid_i,
	input  wire logic             [1:0][31:0] fetch_instr_i,
	output logic                              fetch_ready_o,
	input  wire logic                         lsu_locked_i,
	input  wire logic                         commit_i,
	output logic                        [1:0] issue_valid_o,
	output issue_pkg::fu_t              [1:0] issue_fu_o,
	output issue_pkg::rob_tag_t         [1:0] issue_tag_o,
	output logic                        [1:0] issue_delayslot_o,
	output logic                   [1:0][1:0] issue_src_ready_o,
	output issue_pkg::rob_tag_t    [1:0][1:0] issue_src_tag_o
);

	logic                            [1:0] head_valid;
	issue_pkg::instr_word_u          [1:0] head_instr;
	issue_pkg::decoded_instr_t       [1:0] decoded;
	logic                            [1:0] pop_count;
	issue_pkg::reg_addr_t            [3:0] src_addr;
	logic                            [3:0] src_busy;
	issue_pkg::rob_tag_t             [3:0] src_tag;
	logic                            [1:0] status_we;
	issue_pkg::reg_addr_t            [1:0] status_rd;
	issue_pkg::rob_tag_t             [1:0] status_tag;
	issue_pkg::rob_tag_t             [1:0] rob_tag;
	logic                                  rob_full;
	logic                                  clear;
	issue_pkg::reg_addr_t                  clear_rd;
	issue_pkg::rob_tag_t                   clear_tag;

	fetch_queue u_fetch_queue (
		.clk          ( clk           ),
		.reset_i      ( reset_i       ),
		.push_valid_i ( fetch_valid_i ),
		.push_instr_i ( fetch_instr_i ),
		.push_ready_o ( fetch_ready_o ),
		.pop_count_i  ( pop_count     ),
		.head_valid_o ( head_valid    ),
		.head_instr_o ( head_instr    )
	);

	for (genvar i = 0; i < 2; i++) begin : gen_decoder
		instr_decoder u_instr_decoder (
			.instr_i   ( head_instr[i] ),
			.decoded_o ( decoded[i]    )
		);
	end

	pair_issue u_pair_issue (
		.clk               ( clk               ),
		.reset_i           ( reset_i           ),
		.head_valid_i      ( head_valid        ),
		.decoded_i         ( decoded           ),
		.lsu_locked_i      ( lsu_locked_i      ),
		.rob_full_i        ( rob_full          ),
		.rob_tag_i         ( rob_tag           ),
		.src_busy_i        ( src_busy          ),
		.src_tag_i         ( src_tag           ),
		.pop_count_o       ( pop_count         ),
		.src_addr_o        ( src_addr          ),
		.status_we_o       ( status_we         ),
		.status_rd_o       ( status_rd         ),
		.status_tag_o      ( status_tag        ),
		.issue_valid_o     ( issue_valid_o     ),
		.issue_fu_o        ( issue_fu_o        ),
		.issue_tag_o       ( issue_tag_o       ),
		.issue_delayslot_o ( issue_delayslot_o ),
		.issue_src_ready_o ( issue_src_ready_o ),
		.issue_src_tag_o   ( issue_src_tag_o   )
	);

	reg_status_table u_reg_status_table (
		.clk         ( clk        ),
		.reset_i     ( reset_i    ),
		.raddr_i     ( src_addr   ),
		.rbusy_o     ( src_busy   ),
		.rtag_o      ( src_tag    ),
		.we_i        ( status_we  ),
		.waddr_i     ( status_rd  ),
		.wtag_i      ( status_tag ),
		.clear_i     ( clear      ),
		.clear_rd_i  ( clear_rd   ),
		.clear_tag_i ( clear_tag  )
	);

	// the pop count is the number of issuing slots
	rob_alloc u_rob_alloc (
		.clk           ( clk       ),
		.reset_i       ( reset_i   ),
		.issue_count_i ( pop_count ),
		.issue_rd_i    ( status_rd ),
		.commit_i      ( commit_i  ),
		.next_tag_o    ( rob_tag   ),
		.rob_full_o    ( rob_full  ),
		.clear_o       ( clear     ),
		.clear_rd_o    ( clear_rd  ),
		.clear_tag_o   ( clear_tag )
	);

endmodule

`default_nettype wire

// File: sim/issue_model.svh
// expected packet, slot 1 fields only hold when valid[1] is set
typedef struct packed {
	logic      [1:0]      valid;
	fu_t       [1:0]      fu;
	rob_tag_t  [1:0]      tag;
	logic                 ds1;
	logic      [1:0][1:0] rdy;
	rob_tag_t  [1:0][1:0] stag;
} packet_t;

logic [31:0] m_queue [$];
logic [`ISSUE_REG_COUNT-1:0] m_busy = '0;
rob_tag_t    m_tag [`ISSUE_REG_COUNT] = '{default: '0};
reg_addr_t   m_rd [`ISSUE_ROB_DEPTH] = '{default: '0};
rob_tag_t    m_head = '0;
rob_tag_t    m_tail = '0;
int          m_count = 0;
int          m_pushed = 0;
logic        m_popped = 1'b0;
packet_t     exp_q [$];

function automatic decoded_instr_t decode_word(input logic [31:0] word);
	instr_word_u    w;
	decoded_instr_t d;
	logic [5:0]     op;
	logic [5:0]     fn;
	w  = word;
	op = w.r.opcode;
	fn = w.r.funct;
	d  = '0;
	d.fu  = FU_ALU;
	d.rs1 = w.r.rs;
	d.rd  = w.i.rt;
	if (op == OP_SPECIAL) begin
		d.rs2 = w.r.rt;
		d.rd  = w.r.rd;
		if (fn == FN_MULT || fn == FN_MULTU || fn == FN_DIV || fn == FN_DIVU) begin
			d.fu = FU_MUL;
			d.rd = '0;
		end else if (fn == FN_JR || fn == FN_JALR) begin
			d.fu  = FU_BRANCH;
			d.rs2 = '0;
		end
	end else if (op == OP_LW) begin
		d.fu = FU_LOAD;
	end else if (op == OP_SW) begin
		d.fu  = FU_STORE;
		d.rs2 = w.i.rt;
		d.rd  = '0;
	end else if (op == OP_COP0) begin
		d.fu  = FU_CP0;
		d.rs1 = '0;
		// mtc0 reads rt
		if (w.i.rs == CP0_MT) begin
			d.rs2 = w.i.rt;
			d.rd  = '0;
		end
	end else if (op == OP_J || op == OP_JAL) begin
		d.fu  = FU_BRANCH;
		d.rs1 = '0;
		d.rd  = (op == OP_JAL) ? 5'd31 : 5'd0;
	end else if (op >= OP_REGIMM && op <= OP_BGTZ) begin
		// conditional branches, linking regimm forms write r31
		d.fu  = FU_BRANCH;
		d.rs2 = (op == OP_BEQ || op == OP_BNE) ? w.i.rt : 5'd0;
		d.rd  = (op == OP_REGIMM && w.i.rt[4]) ? 5'd31 : 5'd0;
	end
	d.is_controlflow = (d.fu == FU_BRANCH);
	return d;
endfunction

function automatic logic pair_allowed(input decoded_instr_t a, input decoded_instr_t b);
	if (b.is_controlflow) begin
		return 1'b0;
	end
	if (a.fu == FU_MUL || a.fu == FU_CP0 || b.fu == FU_MUL || b.fu == FU_CP0) begin
		return 1'b0;
	end
	return !(a.fu == FU_STORE && (b.fu == FU_STORE || b.fu == FU_LOAD));
endfunction

// one clock edge of the stage, from the state before the edge
task automatic advance_model(input logic [1:0] push_v, input logic [31:0] w0,
		input logic [31:0] w1, input logic lock, input logic commit);
	decoded_instr_t d0;
	decoded_instr_t d1;
	logic           ready;
	logic           ok1;
	logic           stall;
	logic           go0;
	logic           go1;
	reg_addr_t      src [4];
	reg_addr_t      crd;
	packet_t        p;
	ready = (m_queue.size() <= `ISSUE_QUEUE_DEPTH - 2);
	d0 = (m_queue.size() > 0) ? decode_word(m_queue[0]) : '0;
	d1 = (m_queue.size() > 1) ? decode_word(m_queue[1]) : '0;
	// a delay slot rides with its branch past the pairing limits
	ok1 = (m_queue.size() > 1) && !(d1.fu == FU_LOAD && lock)
		&& (d0.is_controlflow || pair_allowed(d0, d1));
	stall = (m_count > `ISSUE_ROB_DEPTH - 2) || (d0.is_controlflow && !ok1);
	go0 = (m_queue.size() > 0) && !stall && !(d0.fu == FU_LOAD && lock);
	go1 = go0 && ok1;
	if (go0) begin
		p = '0;
		p.valid = {go1, 1'b1};
		p.fu[0] = d0.fu;
		p.fu[1] = d1.fu;
		p.tag[0] = m_tail;
		p.tag[1] = m_tail + 1'b1;
		p.ds1 = d0.is_controlflow;
		src[0] = d0.rs1;
		src[1] = d0.rs2;
		src[2] = d1.rs1;
		src[3] = d1.rs2;
		for (int k = 0; k < 4; k++) begin
			p.rdy[k/2][k%2]  = !m_busy[src[k]];
			p.stag[k/2][k%2] = m_tag[src[k]];
			if (k >= 2 && d0.rd != '0 && src[k] == d0.rd) begin
				p.rdy[k/2][k%2]  = 1'b0;
				p.stag[k/2][k%2] = m_tail;
			end
		end
		exp_q.push_back(p);
	end
	if (commit && m_count > 0) begin
		crd = m_rd[m_head];
		if (m_tag[crd] == m_head) begin
			m_busy[crd] = 1'b0;
		end
		m_head  = m_head + 1'b1;
		m_count = m_count - 1;
	end
	for (int s = 0; s < 2; s++) begin
		if ((s == 0 && go0) || (s == 1 && go1)) begin
			crd = (s == 0) ? d0.rd : d1.rd;
			m_rd[m_tail] = crd;
			if (crd != '0) begin
				m_busy[crd] = 1'b1;
				m_tag[crd]  = m_tail;
			end
			m_tail  = m_tail + 1'b1;
			m_count = m_count + 1;
			m_queue.delete(0);
		end
	end
	m_popped = go0;
	if (ready && push_v[0]) begin
		m_queue.push_back(w0);
		m_pushed++;
		if (push_v[1]) begin
			m_queue.push_back(w1);
			m_pushed++;
		end
	end
endtask

// File: sim/tb_issue_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module tb_issue_stage import issue_pkg::*; ();

	logic                  clk;
	logic                  reset_i;
	logic            [1:0] fetch_valid_i;
	logic      [1:0][31:0] fetch_instr_i;
	logic                  fetch_ready_o;
	logic                  lsu_locked_i;
	logic                  commit_i;
	logic            [1:0] issue_valid_o;
	fu_t             [1:0] issue_fu_o;
	rob_tag_t        [1:0] issue_tag_o;
	logic            [1:0] issue_delayslot_o;
	logic       [1:0][1:0] issue_src_ready_o;
	rob_tag_t   [1:0][1:0] issue_src_tag_o;

	int errors = 0;
	int packets = 0;

	`include "issue_model.svh"

	issue_stage u_issue_stage (
		.clk               ( clk               ),
		.reset_i           ( reset_i           ),
		.fetch_valid_i     ( fetch_valid_i     ),
		.fetch_instr_i     ( fetch_instr_i     ),
		.fetch_ready_o     ( fetch_ready_o     ),
		.lsu_locked_i      ( lsu_locked_i      ),
		.commit_i          ( commit_i          ),
		.issue_valid_o     ( issue_valid_o     ),
		.issue_fu_o        ( issue_fu_o        ),
		.issue_tag_o       ( issue_tag_o       ),
		.issue_delayslot_o ( issue_delayslot_o ),
		.issue_src_ready_o ( issue_src_ready_o ),
		.issue_src_tag_o   ( issue_src_tag_o   )
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error @ %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic [31:0] r_format(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] fn);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_format(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// small register range so dependencies show up often
	function automatic logic [31:0] random_word();
		logic [4:0] a;
		logic [4:0] b;
		logic [4:0] c;
		a = 5'($urandom_range(7, 0));
		b = 5'($urandom_range(7, 0));
		c = 5'($urandom_range(7, 0));
		case ($urandom_range(10, 0))
			0, 1, 2: return r_format(a, b, c, 6'h21);
			3:       return i_format(6'h08, a, b, 16'h0010);
			4:       return i_format(OP_LW, a, b, 16'h0000);
			5:       return i_format(OP_SW, a, b, 16'h0000);
			6:       return i_format(OP_BEQ, a, b, 16'h0004);
			7:       return r_format(a, 5'd0, c, FN_JALR);
			8:       return r_format(a, b, 5'd0, FN_MULT);
			9:       return i_format(OP_COP0, {2'b00, c[0], 2'b00}, b, 16'h6000);
			default: return $urandom;
		endcase
	endfunction

	// entered 2 ns after an edge, returns 2 ns after the next one
	task automatic drive_cycle(input logic [1:0] v, input logic [31:0] w0,
			input logic [31:0] w1, input logic lock, input logic commit);
		fetch_valid_i    = v;
		fetch_instr_i[0] = w0;
		fetch_instr_i[1] = w1;
		lsu_locked_i     = lock;
		commit_i         = commit;
		@(posedge clk);
		advance_model(v, w0, w1, lock, commit);
		#2;
		check_value("fetch_ready_o", fetch_ready_o,
			m_queue.size() <= `ISSUE_QUEUE_DEPTH - 2);
	endtask

	// the source holds its words until there is room
	task automatic push_words(input logic [31:0] w0, input logic [31:0] w1, input int n,
			input logic lock, input logic commit);
		// a full queue drains with the lock off and commits on
		while (m_queue.size() > `ISSUE_QUEUE_DEPTH - 2) begin
			drive_cycle(2'b00, '0, '0, 1'b0, 1'b1);
		end
		drive_cycle((n == 2) ? 2'b11 : 2'b01, w0, w1, lock, commit);
	endtask

	task automatic wait_idle(input logic lock);
		drive_cycle(2'b00, '0, '0, lock, 1'b0);
		while (m_popped || exp_q.size() != 0) begin
			drive_cycle(2'b00, '0, '0, lock, 1'b0);
		end
	endtask

	task automatic retire_all();
		while (m_count > 0) begin
			drive_cycle(2'b00, '0, '0, 1'b0, 1'b1);
		end
	endtask

	initial begin
		packet_t p;
		forever begin
			@(negedge clk);
			if (!reset_i && issue_valid_o != 2'b00) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected issue packet at %0t with nothing due", $time);
				end else begin
					p = exp_q.pop_front();
					packets++;
					check_value("issue_valid_o", issue_valid_o, p.valid);
					for (int s = 0; s < 2; s++) begin
						if (p.valid[s]) begin
							check_value($sformatf("slot %0d unit", s), issue_fu_o[s], p.fu[s]);
							check_value($sformatf("slot %0d tag", s), issue_tag_o[s], p.tag[s]);
							check_value($sformatf("slot %0d delay slot", s),
								issue_delayslot_o[s], (s == 1) ? p.ds1 : 1'b0);
							for (int k = 0; k < 2; k++) begin
								check_value($sformatf("slot %0d src %0d ready", s, k),
									issue_src_ready_o[s][k], p.rdy[s][k]);
								if (!p.rdy[s][k]) begin
									check_value($sformatf("slot %0d src %0d tag", s, k),
										issue_src_tag_o[s][k], p.stag[s][k]);
								end
							end
						end
					end
				end
			end
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > 40 * m_pushed + 200) begin
				$display("timeout: run still going after %0d cycles for %0d pushed words",
					cycles, m_pushed);
				$display("Done: errors found");
				$finish;
			end
		end
	end

	initial begin
		void'($urandom(32'hbf5d));
		reset_i       = 1'b1;
		fetch_valid_i = '0;
		fetch_instr_i = '0;
		lsu_locked_i  = 1'b0;
		commit_i      = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		reset_i = 1'b0;

		// independent alu pairs
		push_words(r_format(2, 3, 1, 6'h21), r_format(5, 6, 4, 6'h21), 2, 1'b0, 1'b0);
		push_words(r_format(8, 9, 7, 6'h21), r_format(11, 12, 10, 6'h21), 2, 1'b0, 1'b0);
		wait_idle(1'b0);
		retire_all();

		// pairing limits
		push_words(r_format(1, 2, 0, FN_MULT), r_format(3, 4, 5, 6'h21), 2, 1'b0, 1'b0);
		push_words(r_format(3, 4, 6, 6'h21), i_format(OP_COP0, 5'd0, 7, 16'h6000),
			2, 1'b0, 1'b0);
		push_words(i_format(OP_SW, 1, 2, 0), i_format(OP_SW, 3, 4, 0), 2, 1'b0, 1'b0);
		push_words(i_format(OP_SW, 1, 2, 0), i_format(OP_LW, 3, 8, 0), 2, 1'b0, 1'b0);
		wait_idle(1'b0);
		push_words(r_format(1, 2, 9, 6'h21), i_format(OP_LW, 3, 10, 0), 2, 1'b1, 1'b0);
		wait_idle(1'b1);
		wait_idle(1'b0);
		retire_all();

		// branch with delay slot, then a branch waiting for its slot
		push_words(i_format(OP_BEQ, 1, 2, 4), r_format(3, 4, 5, 6'h21), 2, 1'b0, 1'b0);
		push_words({OP_JAL, 26'h40}, r_format(31, 4, 6, 6'h21), 2, 1'b0, 1'b0);
		push_words(i_format(OP_BNE, 5, 6, 8), '0, 1, 1'b0, 1'b0);
		wait_idle(1'b0);
		push_words(r_format(7, 8, 9, 6'h21), '0, 1, 1'b0, 1'b0);
		wait_idle(1'b0);
		retire_all();

		// renaming inside a packet and across packets with r0 kept idle
		push_words(r_format(1, 2, 5, 6'h21), r_format(5, 0, 6, 6'h21), 2, 1'b0, 1'b0);
		push_words(r_format(5, 6, 7, 6'h21), r_format(1, 2, 0, 6'h21), 2, 1'b0, 1'b0);
		push_words(r_format(0, 7, 8, 6'h21), r_format(0, 0, 9, 6'h21), 2, 1'b0, 1'b0);
		wait_idle(1'b0);
		retire_all();
		wait_idle(1'b0);

		// fill the reorder buffer, then free it
		for (int i = 0; i < 10; i++) begin
			push_words(r_format(1, 2, 5'(i + 1), 6'h21), r_format(3, 4, 5'(i + 12), 6'h21),
				2, 1'b0, 1'b0);
		end
		wait_idle(1'b0);
		repeat (4) drive_cycle(2'b00, '0, '0, 1'b0, 1'b1);
		wait_idle(1'b0);
		retire_all();
		wait_idle(1'b0);

		// random traffic
		for (int i = 0; i < 150; i++) begin
			push_words(random_word(), random_word(), $urandom_range(2, 1),
				$urandom_range(3, 0) == 0, $urandom_range(1, 0));
			if ($urandom_range(3, 0) == 0) begin
				drive_cycle(2'b00, '0, '0, $urandom_range(3, 0) == 0, $urandom_range(1, 0));
			end
		end
		push_words(r_format(0, 0, 0, 6'h21), r_format(0, 0, 0, 6'h21), 2, 1'b0, 1'b0);
		wait_idle(1'b0);
		retire_all();
		wait_idle(1'b0);

		// one more edge so a late packet still reaches the checker
		drive_cycle(2'b00, '0, '0, 1'b0, 1'b0);

		$display("checked %0d packets, %0d errors", packets, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: issue_stage.f
+incdir+hw
+incdir+sim
hw/issue_pkg.sv
hw/fetch_queue.sv
hw/instr_decoder.sv
hw/pair_issue.sv
hw/reg_status_table.sv
hw/rob_alloc.sv
hw/issue_stage.sv
sim/tb_issue_stage.sv

// File: Bender.yml
package:
  name: issue_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/issue_pkg.sv
      - hw/fetch_queue.sv
      - hw/instr_decoder.sv
      - hw/pair_issue.sv
      - hw/reg_status_table.sv
      - hw/rob_alloc.sv
      - hw/issue_stage.sv
  - target: simulation
    include_dirs:
      - hw
      - sim
    files:
      - sim/tb_issue_stage.sv
